// File: fifo_sync.f
hdl/fifo_cfg_pkg.sv
hdl/fifo_ptr_pkg.sv
hdl/fifo_ptr_counter.sv
hdl/fifo_flag_ctrl.sv
hdl/fifo_storage.sv
hdl/fifo_sync.sv
sim/tb_fifo_sync.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the FIFO testbench with Verilator, once per read-output mode.
# Exits non-zero as soon as a build or a simulation run fails.

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_fifo_sync
FILELIST=fifo_sync.f

run_mode() {
        local name="$1"
        local value="$2"
        local mdir="obj_${name}"

        echo "Building ${TOP} with OUT_MODE=${name}"
        if ! verilator --binary --timing --assert \
                --top-module "${TOP}" \
                -GOUT_MODE="${value}" \
                --Mdir "${mdir}" \
                -f "${FILELIST}"; then
                echo "Verilator build failed for OUT_MODE=${name}"
                exit 1
        fi

        echo "Running ${TOP} with OUT_MODE=${name}"
        if ! "./${mdir}/V${TOP}"; then
                echo "Simulation failed for OUT_MODE=${name}"
                exit 1
        fi
}

run_mode mux "1'b0"
run_mode flop "1'b1"

echo "Both read-output modes ran to completion"
exit 0

// File: sim/fifo_sync_trace.txt
// tag write wr_data read | full almost_full empty almost_empty head (hex)
// One line per cycle, DEPTH 6, both margins 1, head as seen in mux mode
reset 0 00 0 0 0 1 1 00
reset 0 00 0 0 0 1 1 00
fill 1 11 0 0 0 0 1 11
fill 1 22 0 0 0 0 0 11
fill 1 33 0 0 0 0 0 11
fill 1 44 0 0 0 0 0 11
fill 1 55 0 0 1 0 0 11
fill 1 66 0 1 1 0 0 11
full 1 77 0 1 1 0 0 11
full 1 88 0 1 1 0 0 11
drain 0 00 1 0 1 0 0 22
drain 0 00 1 0 0 0 0 33
drain 0 00 1 0 0 0 0 44
drain 0 00 1 0 0 0 0 55
drain 0 00 1 0 0 0 1 66
drain 0 00 1 0 0 1 1 00
empty 0 00 1 0 0 1 1 00
empty 0 00 1 0 0 1 1 00
simul 1 a1 0 0 0 0 1 a1
simul 1 a2 0 0 0 0 0 a1
simul 1 a3 0 0 0 0 0 a1
simul 1 b1 1 0 0 0 0 a2
simul 1 b2 1 0 0 0 0 a3
simul 1 b3 1 0 0 0 0 b1
simul 1 b4 1 0 0 0 0 b2
wrap 0 00 1 0 0 0 0 b3
wrap 0 00 1 0 0 0 1 b4
wrap 1 c1 1 0 0 0 1 c1
wrap 1 c2 1 0 0 0 1 c2
wrap 1 c3 0 0 0 0 0 c2
wrap 1 c4 1 0 0 0 0 c3
wrap 1 c5 0 0 0 0 0 c3
wrap 1 c6 0 0 0 0 0 c3
wrap 1 c7 0 0 1 0 0 c3
wrap 1 c8 1 0 1 0 0 c4
wrap 1 c9 0 1 1 0 0 c4
wrap 1 ca 1 0 1 0 0 c5
wrap 1 ca 1 0 1 0 0 c6
wrap 1 cb 1 0 1 0 0 c7
wrap 0 00 1 0 0 0 0 c8
wrap 0 00 1 0 0 0 0 c9
wrap 0 00 1 0 0 0 0 ca
wrap 1 cc 1 0 0 0 0 cb
wrap 0 00 1 0 0 0 1 cc
wrap 0 00 1 0 0 1 1 00
wrap 1 cd 1 0 0 0 1 cd
wrap 0 00 1 0 0 1 1 00

// File: sim/tb_fifo_sync.sv
/*
 * Trace-driven testbench for the synchronous FIFO.
 * Each trace line is one cycle of requests plus the expected flags and head.
 * OUT_MODE selects the read-output mode under test.
 */

`timescale 1ns/1ps

module tb_fifo_sync #(
        parameter bit OUT_MODE = fifo_cfg_pkg::OUT_MUX
);

        localparam int DW = fifo_cfg_pkg::DEF_DATA_WIDTH;
        localparam int MAX_LINES = 256;
        localparam int RESET_CYCLES = 16;
        localparam int SETTLE_LIMIT = 8;

        logic          clk;
        logic          rst_n;
        logic          i_write;
        logic [DW-1:0] i_wr_data;
        logic          i_read;
        logic [DW-1:0] o_rd_data;
        logic          o_wr_full;
        logic          o_wr_almost_full;
        logic          o_rd_empty;
        logic          o_rd_almost_empty;

        // Trace contents, one slot per cycle
        logic [127:0]  tr_tag [MAX_LINES];
        logic          tr_write [MAX_LINES];
        logic [DW-1:0] tr_data [MAX_LINES];
        logic          tr_read [MAX_LINES];
        logic          tr_full [MAX_LINES];
        logic          tr_afull [MAX_LINES];
        logic          tr_empty [MAX_LINES];
        logic          tr_aempty [MAX_LINES];
        logic [DW-1:0] tr_head [MAX_LINES];
        int            n_lines;

        // Line under check, shown in error lines
        string         cur_tag;
        int            cur_line;

        fifo_sync #(
                .DATA_WIDTH       (DW),
                .DEPTH            (fifo_cfg_pkg::DEF_DEPTH),
                .ALMOST_WR_MARGIN (fifo_cfg_pkg::DEF_ALMOST_WR_MARGIN),
                .ALMOST_RD_MARGIN (fifo_cfg_pkg::DEF_ALMOST_RD_MARGIN),
                .OUT_MODE         (fifo_cfg_pkg::out_mode_e'(OUT_MODE))
        ) fifo_sync_i (
                .clk               (clk),
                .rst_n             (rst_n),
                .i_write           (i_write),
                .i_wr_data         (i_wr_data),
                .i_read            (i_read),
                .o_rd_data         (o_rd_data),
                .o_wr_full         (o_wr_full),
                .o_wr_almost_full  (o_wr_almost_full),
                .o_rd_empty        (o_rd_empty),
                .o_rd_almost_empty (o_rd_almost_empty)
        );

        // 100 ns period
        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        // ----------------------------------------------------------
        // Helpers
        // ----------------------------------------------------------
        task automatic abort_run(input string reason);
                $display("%0s", reason);
                $display("CHECKS FAILED");
                $fatal(1, "simulation stopped at the first error");
        endtask

        task automatic check_value(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
                if (actual !== expected) begin
                        abort_run($sformatf("[FAIL] %0s line %0d %0s expected %h actual %h",
                                            cur_tag, cur_line, what, expected, actual));
                end
        endtask

        // Fields per line are tag, write, data, read, then four flags and the mux head
        task automatic load_trace();
                int           fd;
                int           rc;
                int           raw;
                string        line;
                logic [127:0] f_tag;
                logic [7:0]   f [8];

                n_lines = 0;
                raw = 0;
                fd = $fopen("sim/fifo_sync_trace.txt", "r");
                if (fd == 0) begin
                        abort_run("cannot open the trace file sim/fifo_sync_trace.txt");
                end
                while (!$feof(fd)) begin
                        if (raw >= 4 * MAX_LINES) begin
                                abort_run("reading the trace file did not finish");
                        end
                        raw++;
                        rc = $fgets(line, fd);
                        if (rc == 0) begin
                                break;
                        end
                        // Comments and blank lines
                        if (line.len() < 2 || line.getc(0) == "/") begin
                                continue;
                        end
                        rc = $sscanf(line, "%s %h %h %h %h %h %h %h %h", f_tag,
                                     f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                        if (rc != 9) begin
                                abort_run($sformatf("trace file line %0d is malformed", raw));
                        end
                        if (n_lines >= MAX_LINES) begin
                                abort_run("trace file holds more cycles than the testbench can");
                        end
                        tr_tag[n_lines]    = f_tag;
                        tr_write[n_lines]  = f[0][0];
                        tr_data[n_lines]   = f[1];
                        tr_read[n_lines]   = f[2][0];
                        tr_full[n_lines]   = f[3][0];
                        tr_afull[n_lines]  = f[4][0];
                        tr_empty[n_lines]  = f[5][0];
                        tr_aempty[n_lines] = f[6][0];
                        tr_head[n_lines]   = f[7];
                        n_lines++;
                end
                $fclose(fd);
                if (n_lines == 0) begin
                        abort_run("trace file holds no cycles");
                end
        endtask

        // Requests of one line, taken by the DUT on the following edge
        task automatic drive_line(input int idx);
                i_write   <= tr_write[idx];
                i_wr_data <= tr_data[idx];
                i_read    <= tr_read[idx];
        endtask

        task automatic check_line(input int idx);
                cur_tag  = $sformatf("%0s", tr_tag[idx]);
                cur_line = idx;
                check_value("o_wr_full", 32'(tr_full[idx]), 32'(o_wr_full));
                check_value("o_wr_almost_full", 32'(tr_afull[idx]), 32'(o_wr_almost_full));
                check_value("o_rd_empty", 32'(tr_empty[idx]), 32'(o_rd_empty));
                check_value("o_rd_almost_empty", 32'(tr_aempty[idx]), 32'(o_rd_almost_empty));
                if (OUT_MODE == fifo_cfg_pkg::OUT_FLOP) begin
                        // Registered head lags the mux view by one line
                        if (idx > 0 && !tr_empty[idx-1]) begin
                                check_value("o_rd_data", 32'(tr_head[idx-1]), 32'(o_rd_data));
                        end
                end else if (!tr_empty[idx]) begin
                        check_value("o_rd_data", 32'(tr_head[idx]), 32'(o_rd_data));
                end
        endtask

        // ----------------------------------------------------------
        // Main sequence
        // ----------------------------------------------------------
        initial begin
                int cycles;
                int idx;

                rst_n     <= 1'b0;
                i_write   <= 1'b0;
                i_wr_data <= '0;
                i_read    <= 1'b0;
                cur_tag   = "reset";
                cur_line  = -1;
                load_trace();

                cycles = 0;
                while (cycles < RESET_CYCLES) begin
                        @(posedge clk);
                        cycles++;
                end
                rst_n <= 1'b1;

                // Wait for the empty flag out of reset
                cycles = 0;
                @(negedge clk);
                while (o_rd_empty !== 1'b1) begin
                        if (cycles >= SETTLE_LIMIT) begin
                                abort_run("FIFO did not report empty after reset");
                        end
                        @(negedge clk);
                        cycles++;
                end

                // Reset state
                check_value("o_wr_full", 32'(1'b0), 32'(o_wr_full));
                check_value("o_wr_almost_full", 32'(1'b0), 32'(o_wr_almost_full));
                check_value("o_rd_almost_empty", 32'(1'b1), 32'(o_rd_almost_empty));
                if (OUT_MODE == fifo_cfg_pkg::OUT_FLOP) begin
                        check_value("o_rd_data", 32'(0), 32'(o_rd_data));
                end

                // One trace line per cycle, checked mid-cycle after its edge
                @(posedge clk);
                drive_line(0);
                for (idx = 0; idx < n_lines; idx++) begin
                        @(posedge clk);
                        if (idx + 1 < n_lines) begin
                                drive_line(idx + 1);
                        end else begin
                                i_write <= 1'b0;
                                i_read  <= 1'b0;
                        end
                        @(negedge clk);
                        check_line(idx);
                end

                $display("ALL CHECKS PASSED");
                $finish;
        end

endmodule

// File: hdl/fifo_sync.sv
/*
 * Single-clock synchronous FIFO top level.
 * Write with i_write unless full, read with i_read unless empty.
 * Any DEPTH is allowed; OUT_MODE selects mux or registered read data.
 */

`timescale 1ns/1ps

module fifo_sync #(
        parameter int                      DATA_WIDTH = fifo_cfg_pkg::DEF_DATA_WIDTH,
        parameter int                      DEPTH = fifo_cfg_pkg::DEF_DEPTH,
        parameter int                      ALMOST_WR_MARGIN = fifo_cfg_pkg::DEF_ALMOST_WR_MARGIN,
        parameter int                      ALMOST_RD_MARGIN = fifo_cfg_pkg::DEF_ALMOST_RD_MARGIN,
        parameter fifo_cfg_pkg::out_mode_e OUT_MODE = fifo_cfg_pkg::OUT_MUX
) (
        input  logic                  clk,
        input  logic                  rst_n,
        input  logic                  i_write,
        input  logic [DATA_WIDTH-1:0] i_wr_data,
        input  logic                  i_read,
        output logic [DATA_WIDTH-1:0] o_rd_data,
        output logic                  o_wr_full,
        output logic                  o_wr_almost_full,
        output logic                  o_rd_empty,
        output logic                  o_rd_almost_empty
);

        localparam int AW = fifo_ptr_pkg::addr_bits(DEPTH);
        localparam int PW = fifo_ptr_pkg::ptr_bits(DEPTH);

        // Accept strobes, one source each
        logic          wr_accept;
        logic          rd_accept;

        // Current and next pointers, lap bit on top
        logic [PW-1:0] wr_ptr;
        logic [PW-1:0] wr_ptr_next;
        logic [PW-1:0] rd_ptr;
        logic [PW-1:0] rd_ptr_next;

        // ----------------------------------------------------------
        // Pointers
        // ----------------------------------------------------------
        fifo_ptr_counter #(
                .DEPTH (DEPTH)
        ) wr_ptr_i (
                .clk        (clk),
                .rst_n      (rst_n),
                .i_advance  (wr_accept),
                .o_ptr      (wr_ptr),
                .o_ptr_next (wr_ptr_next)
        );

        fifo_ptr_counter #(
                .DEPTH (DEPTH)
        ) rd_ptr_i (
                .clk        (clk),
                .rst_n      (rst_n),
                .i_advance  (rd_accept),
                .o_ptr      (rd_ptr),
                .o_ptr_next (rd_ptr_next)
        );

        // ----------------------------------------------------------
        // Accept gating and flags
        // ----------------------------------------------------------
        fifo_flag_ctrl #(
                .DEPTH            (DEPTH),
                .ALMOST_WR_MARGIN (ALMOST_WR_MARGIN),
                .ALMOST_RD_MARGIN (ALMOST_RD_MARGIN)
        ) flag_ctrl_i (
                .clk               (clk),
                .rst_n             (rst_n),
                .i_write           (i_write),
                .i_read            (i_read),
                .i_wr_ptr_next     (wr_ptr_next),
                .i_rd_ptr_next     (rd_ptr_next),
                .o_wr_accept       (wr_accept),
                .o_rd_accept       (rd_accept),
                .o_wr_full         (o_wr_full),
                .o_wr_almost_full  (o_wr_almost_full),
                .o_rd_empty        (o_rd_empty),
                .o_rd_almost_empty (o_rd_almost_empty)
        );

        // ----------------------------------------------------------
        // Entry storage
        // ----------------------------------------------------------

        // Addresses are the pointers without the lap bit
        fifo_storage #(
                .DATA_WIDTH (DATA_WIDTH),
                .DEPTH      (DEPTH),
                .OUT_MODE   (OUT_MODE)
        ) storage_i (
                .clk       (clk),
                .rst_n     (rst_n),
                .i_wr_en   (wr_accept),
                .i_wr_addr (wr_ptr[AW-1:0]),
                .i_rd_addr (rd_ptr[AW-1:0]),
                .i_wr_data (i_wr_data),
                .o_rd_data (o_rd_data)
        );

endmodule

// File: hdl/fifo_storage.sv
/*
 * Entry memory of the synchronous FIFO.
 * One write port and one read port addressed by the pointer address fields.
 * OUT_MODE picks a combinational head or a registered head.
 */

`timescale 1ns/1ps

module fifo_storage #(
        parameter int                    DATA_WIDTH = 8,
        parameter int                    DEPTH = 6,
        parameter fifo_cfg_pkg::out_mode_e OUT_MODE = fifo_cfg_pkg::OUT_MUX
) (
        input  logic                                      clk,
        input  logic                                      rst_n,
        input  logic                                      i_wr_en,
        input  logic [fifo_ptr_pkg::addr_bits(DEPTH)-1:0] i_wr_addr,
        input  logic [fifo_ptr_pkg::addr_bits(DEPTH)-1:0] i_rd_addr,
        input  logic [DATA_WIDTH-1:0]                     i_wr_data,
        output logic [DATA_WIDTH-1:0]                     o_rd_data
);

        // One entry per slot, no reset on the array
        logic [DATA_WIDTH-1:0] mem [DEPTH];

        // ----------------------------------------------------------
        // Write port
        // ----------------------------------------------------------

        // Lands one cycle after the accept
        always_ff @(posedge clk) begin
                if (i_wr_en) begin
                        mem[i_wr_addr] <= i_wr_data;
                end
        end

        // ----------------------------------------------------------
        // Read port
        // ----------------------------------------------------------
        if (OUT_MODE == fifo_cfg_pkg::OUT_FLOP) begin : gen_flop
                logic [DATA_WIDTH-1:0] rd_data_q;

                // Head sampled every edge, one cycle behind the mux view
                always_ff @(posedge clk) begin
                        if (!rst_n) begin
                                rd_data_q <= '0;
                        end else begin
                                rd_data_q <= mem[i_rd_addr];
                        end
                end

                assign o_rd_data = rd_data_q;
        end else begin : gen_mux
                // Head entry straight off the array
                assign o_rd_data = mem[i_rd_addr];
        end

endmodule

// File: hdl/fifo_flag_ctrl.sv
/*
 * Accept gating and status flags for the synchronous FIFO.
 * Requests are qualified by the registered full and empty flags.
 * Occupancy comes from the next pointers, so flags track the latest edge.
 */

`timescale 1ns/1ps

module fifo_flag_ctrl #(
        parameter int DEPTH = 6,
        parameter int ALMOST_WR_MARGIN = 1,
        parameter int ALMOST_RD_MARGIN = 1
) (
        input  logic                                     clk,
        input  logic                                     rst_n,
        input  logic                                     i_write,
        input  logic                                     i_read,
        input  logic [fifo_ptr_pkg::ptr_bits(DEPTH)-1:0] i_wr_ptr_next,
        input  logic [fifo_ptr_pkg::ptr_bits(DEPTH)-1:0] i_rd_ptr_next,
        output logic                                     o_wr_accept,
        output logic                                     o_rd_accept,
        output logic                                     o_wr_full,
        output logic                                     o_wr_almost_full,
        output logic                                     o_rd_empty,
        output logic                                     o_rd_almost_empty
);

        localparam int AW = fifo_ptr_pkg::addr_bits(DEPTH);
        localparam int PW = fifo_ptr_pkg::ptr_bits(DEPTH);
        localparam int LAP = AW + fifo_ptr_pkg::LAP_OFFSET;
        localparam logic [PW-1:0] DEPTH_P = PW'(DEPTH);

        // Almost-full already holds at zero occupancy for tiny depths
        localparam logic AFULL_RST = (DEPTH <= ALMOST_WR_MARGIN);

        logic [PW-1:0] occ_next;
        logic [PW-1:0] free_next;
        logic          full_q;
        logic          almost_full_q;
        logic          empty_q;
        logic          almost_empty_q;

        // ----------------------------------------------------------
        // Accept strobes
        // ----------------------------------------------------------

        // Blocked requests are simply dropped
        assign o_wr_accept = i_write & ~full_q;
        assign o_rd_accept = i_read & ~empty_q;

        // ----------------------------------------------------------
        // Occupancy from next pointers
        // ----------------------------------------------------------

        // Same lap means plain difference
        // Different lap means the writer has wrapped once more
        always_comb begin
                occ_next = {1'b0, i_wr_ptr_next[AW-1:0]} - {1'b0, i_rd_ptr_next[AW-1:0]};
                if (i_wr_ptr_next[LAP] != i_rd_ptr_next[LAP]) begin
                        occ_next = occ_next + DEPTH_P;
                end
        end

        assign free_next = DEPTH_P - occ_next;

        // ----------------------------------------------------------
        // Registered flags
        // ----------------------------------------------------------

        // Empty comes straight from matching pointers
        // Full and the almost flags use the occupancy
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        full_q         <= 1'b0;
                        almost_full_q  <= AFULL_RST;
                        empty_q        <= 1'b1;
                        almost_empty_q <= 1'b1;
                end else begin
                        full_q         <= (occ_next == DEPTH_P);
                        almost_full_q  <= (free_next <= ALMOST_WR_MARGIN);
                        empty_q        <= (i_wr_ptr_next == i_rd_ptr_next);
                        almost_empty_q <= (occ_next <= ALMOST_RD_MARGIN);
                end
        end

        assign o_wr_full         = full_q;
        assign o_wr_almost_full  = almost_full_q;
        assign o_rd_empty        = empty_q;
        assign o_rd_almost_empty = almost_empty_q;

        // Pointers from both counters never imply an impossible fill
        a_occ_bound: assert property (@(posedge clk) disable iff (!rst_n)
                occ_next <= DEPTH_P);

        // Lap-corrected fill of DEPTH never meets matching pointers
        a_full_empty_excl: assert property (@(posedge clk) disable iff (!rst_n)
                !(full_q && empty_q));

endmodule

// File: hdl/fifo_ptr_counter.sv
/*
 * Wrapping FIFO pointer with a lap bit.
 * The address runs 0 to DEPTH-1 and the lap bit flips on each wrap,
 * so any depth works. Used for both the read and the write pointer.
 */

`timescale 1ns/1ps

module fifo_ptr_counter #(
        parameter int DEPTH = 6
) (
        input  logic                                     clk,
        input  logic                                     rst_n,
        input  logic                                     i_advance,
        output logic [fifo_ptr_pkg::ptr_bits(DEPTH)-1:0] o_ptr,
        output logic [fifo_ptr_pkg::ptr_bits(DEPTH)-1:0] o_ptr_next
);

        localparam int AW = fifo_ptr_pkg::addr_bits(DEPTH);
        localparam int PW = fifo_ptr_pkg::ptr_bits(DEPTH);
        localparam int LAP = AW + fifo_ptr_pkg::LAP_OFFSET;
        localparam logic [AW-1:0] LAST_ADDR = AW'(DEPTH - 1);

        logic [PW-1:0] ptr_q;
        logic [PW-1:0] ptr_next;

        // Next value, the register takes it on the coming edge
        always_comb begin
                ptr_next = ptr_q;
                if (i_advance) begin
                        if (ptr_q[AW-1:0] == LAST_ADDR) begin
                                // Wrap to zero and start a new lap
                                ptr_next[AW-1:0] = '0;
                                ptr_next[LAP]    = ~ptr_q[LAP];
                        end else begin
                                ptr_next[AW-1:0] = ptr_q[AW-1:0] + 1'b1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        ptr_q <= '0;
                end else begin
                        ptr_q <= ptr_next;
                end
        end

        assign o_ptr      = ptr_q;
        assign o_ptr_next = ptr_next;

        // Address stays inside the entry range across every wrap
        a_addr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
                ptr_q[AW-1:0] < DEPTH);

endmodule

// File: hdl/fifo_ptr_pkg.sv
/*
 * Pointer geometry for the FIFO.
 * A pointer is an address field with a lap bit above it.
 * Counters, flag logic and storage all size their vectors from here.
 */

package fifo_ptr_pkg;

        // Lap bit index relative to the address width
        // Zero puts it directly above the address bits
        localparam int LAP_OFFSET = 0;

        // Address width for a depth
        // Ceiling of log2, never below one bit
        function automatic int addr_bits(input int depth);
                int width;
                width = (depth > 1) ? $clog2(depth) : 1;
                return width;
        endfunction

        // Full pointer width, address plus lap bit
        function automatic int ptr_bits(input int depth);
                int width;
                width = addr_bits(depth) + LAP_OFFSET + 1;
                return width;
        endfunction

endpackage

// File: hdl/fifo_cfg_pkg.sv
/*
 * FIFO configuration types and defaults.
 * The output mode enum selects how the read port presents the head entry.
 * The top level takes its parameter defaults from here.
 */

package fifo_cfg_pkg;

        // ----------------------------------------------------------
        // Read-output mode
        // ----------------------------------------------------------

        // OUT_MUX shows the head combinationally
        // OUT_FLOP registers the head, one cycle later
        typedef enum logic {
                OUT_MUX  = 1'b0,
                OUT_FLOP = 1'b1
        } out_mode_e;

        // ----------------------------------------------------------
        // Default sizes and margins
        // ----------------------------------------------------------
        localparam int DEF_DATA_WIDTH = 8;
        localparam int DEF_DEPTH = 6;

        // Free entries left when almost-full rises
        localparam int DEF_ALMOST_WR_MARGIN = 1;
        // Entries held when almost-empty rises
        localparam int DEF_ALMOST_RD_MARGIN = 1;

endpackage
